//--- logic/xoodoo_pkg.sv
`default_nettype none

package xoodoo_pkg;

        // ------------------------------------------------------------------------
        // State geometry
        // ------------------------------------------------------------------------

        // Bits per lane, lanes per plane, planes per state
        localparam int LANE_W     = 32;
        localparam int NUM_LANES  = 4;
        localparam int NUM_PLANES = 3;

        // Full permutation width
        localparam int STATE_W    = LANE_W * NUM_LANES * NUM_PLANES;

        // Rounds in one Xoodoo permutation
        localparam int NUM_ROUNDS = 12;

        // One lane, bit index is z
        typedef logic [LANE_W-1:0] lane_t;

        // One plane, lane 0 in the low bits
        typedef lane_t [NUM_LANES-1:0] plane_t;

        // Whole state indexed [plane][lane][z], plane 0 in the low bits
        typedef plane_t [NUM_PLANES-1:0] state_t;

        // ------------------------------------------------------------------------
        // Round constants
        // ------------------------------------------------------------------------

        // Constant is 12 bits wide, placed at z = 0 upward in lane 0 of plane 0
        typedef logic [11:0] rc_t;

        // Index of a round within the permutation
        typedef logic [3:0] round_idx_t;

        // Constants in round order, round 0 first
        localparam rc_t ROUND_CONST [NUM_ROUNDS] = '{
                12'h058,
                12'h038,
                12'h3C0,
                12'h0D0,
                12'h120,
                12'h014,
                12'h060,
                12'h02C,
                12'h380,
                12'h0F0,
                12'h1A0,
                12'h012
        };

        // ------------------------------------------------------------------------
        // Control
        // ------------------------------------------------------------------------

        // Waiting for input, iterating round groups, presenting the result
        typedef enum logic [1:0] {
                IDLE,
                RUN,
                HOLD
        } ctrl_state_e;

endpackage

`default_nettype wire

//--- logic/xoodoo_round.sv
`timescale 1ns/1ps
`default_nettype none

module xoodoo_round import xoodoo_pkg::*; (
        input  state_t state_in,
        input  rc_t    rc,
        output state_t state_out
);

        // Barrel rotation toward higher z
        function automatic lane_t rotl(input lane_t v, input int unsigned n);
                rotl = (v << n) | (v >> (LANE_W - n));
        endfunction

        // Column parity and the theta effect
        plane_t p;
        plane_t e;

        // Intermediate states, one per step
        state_t theta;
        state_t west;
        state_t chi;
        state_t east;

        // ------------------------------------------------------------------------
        // Theta
        // ------------------------------------------------------------------------

        // P is the XOR of the three planes
        // E takes P shifted by one lane, rotated by 5 and by 14 bits
        always_comb begin
                p = state_in[0] ^ state_in[1] ^ state_in[2];
                for (int x = 0; x < NUM_LANES; x++) begin
                        e[x] = rotl(p[(x + NUM_LANES - 1) % NUM_LANES], 5) ^
                               rotl(p[(x + NUM_LANES - 1) % NUM_LANES], 14);
                end
                for (int y = 0; y < NUM_PLANES; y++) begin
                        theta[y] = state_in[y] ^ e;
                end
        end

        // ------------------------------------------------------------------------
        // Rho-west and iota
        // ------------------------------------------------------------------------

        always_comb begin
                // Plane 0 only picks up the round constant
                west[0] = theta[0];
                west[0][0] = theta[0][0] ^ lane_t'(rc);
                for (int x = 0; x < NUM_LANES; x++) begin
                        // Plane 1 moves one lane toward higher x
                        west[1][x] = theta[1][(x + NUM_LANES - 1) % NUM_LANES];
                        // Plane 2 rotates 11 bits in z
                        west[2][x] = rotl(theta[2][x], 11);
                end
        end

        // ------------------------------------------------------------------------
        // Chi
        // ------------------------------------------------------------------------

        // Each plane is XORed with the AND of the other two, one inverted
        always_comb begin
                chi[0] = west[0] ^ (~west[1] & west[2]);
                chi[1] = west[1] ^ (~west[2] & west[0]);
                chi[2] = west[2] ^ (~west[0] & west[1]);
        end

        // ------------------------------------------------------------------------
        // Rho-east
        // ------------------------------------------------------------------------

        always_comb begin
                // Plane 0 passes through
                east[0] = chi[0];
                for (int x = 0; x < NUM_LANES; x++) begin
                        // Plane 1 rotates by one bit
                        east[1][x] = rotl(chi[1][x], 1);
                        // Plane 2 moves two lanes and 8 bits
                        east[2][x] = rotl(chi[2][(x + 2) % NUM_LANES], 8);
                end
        end

        // Round result feeds the next round or the state register
        assign state_out = east;

endmodule

`default_nettype wire

//--- logic/xoodoo_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module xoodoo_datapath import xoodoo_pkg::*; #(
        parameter int ROUNDS_PER_CYCLE = 3
) (
        input  logic       eph1,
        input  logic       rst_n,
        input  logic       load,
        input  logic       advance,
        input  state_t     in_state,
        input  round_idx_t round_base,
        output state_t     state_q
);

        // ------------------------------------------------------------------------
        // Round chain
        // ------------------------------------------------------------------------

        // Tap 0 is the register, tap N is the result after N rounds
        state_t chain [ROUNDS_PER_CYCLE+1];

        assign chain[0] = state_q;

        for (genvar j = 0; j < ROUNDS_PER_CYCLE; j++) begin : g_round
                // Position of this round inside the group
                localparam round_idx_t OFFSET = round_idx_t'(j);

                // Absolute round number and its constant
                round_idx_t round_idx;
                rc_t        rc;

                assign round_idx = round_base + OFFSET;
                assign rc        = ROUND_CONST[round_idx];

                xoodoo_round xoodoo_round_i (
                        .state_in  (chain[j]),
                        .rc        (rc),
                        .state_out (chain[j+1])
                );
        end

        // ------------------------------------------------------------------------
        // State register
        // ------------------------------------------------------------------------

        // Load takes priority, the controller never raises both
        // Holds while waiting for input and while the result is presented
        always_ff @(posedge eph1 or negedge rst_n) begin
                if (!rst_n) begin
                        state_q <= '0;
                end else if (load) begin
                        state_q <= in_state;
                end else if (advance) begin
                        state_q <= chain[ROUNDS_PER_CYCLE];
                end
        end

endmodule

`default_nettype wire

//--- logic/xoodoo_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module xoodoo_ctrl import xoodoo_pkg::*; #(
        parameter int ROUNDS_PER_CYCLE = 3
) (
        input  logic       eph1,
        input  logic       rst_n,
        input  logic       in_valid,
        input  logic       out_ready,
        output logic       in_ready,
        output logic       out_valid,
        output logic       load,
        output logic       advance,
        output round_idx_t round_base
);

        // Counter step per clock and the first round of the final group
        localparam round_idx_t STEP      = round_idx_t'(ROUNDS_PER_CYCLE);
        localparam round_idx_t LAST_BASE = round_idx_t'(NUM_ROUNDS - ROUNDS_PER_CYCLE);

        ctrl_state_e state;
        ctrl_state_e state_next;

        // First round of the group applied on the coming edge
        round_idx_t group_ctr;

        // Final group is being applied this cycle
        logic last_group;

        // ------------------------------------------------------------------------
        // Handshake and datapath strobes
        // ------------------------------------------------------------------------

        // Single item in flight, so input is only taken while idle
        assign in_ready  = (state == IDLE);
        assign out_valid = (state == HOLD);

        // Accept happens on the same edge as the load
        assign load    = in_ready & in_valid;
        assign advance = (state == RUN);

        assign last_group = advance & (group_ctr == LAST_BASE);
        assign round_base = group_ctr;

        // ------------------------------------------------------------------------
        // FSM
        // ------------------------------------------------------------------------

        always_comb begin
                state_next = state;
                case (state)
                        IDLE: begin
                                if (in_valid) begin
                                        state_next = RUN;
                                end
                        end
                        RUN: begin
                                // Result is in the register after this edge
                                if (last_group) begin
                                        state_next = HOLD;
                                end
                        end
                        HOLD: begin
                                // Back-pressure keeps us here
                                if (out_ready) begin
                                        state_next = IDLE;
                                end
                        end
                        default: begin
                                state_next = IDLE;
                        end
                endcase
        end

        always_ff @(posedge eph1 or negedge rst_n) begin
                if (!rst_n) begin
                        state <= IDLE;
                end else begin
                        state <= state_next;
                end
        end

        // Round-group counter, parked on the last group until the next load
        always_ff @(posedge eph1 or negedge rst_n) begin
                if (!rst_n) begin
                        group_ctr <= '0;
                end else if (load) begin
                        group_ctr <= '0;
                end else if (advance && !last_group) begin
                        group_ctr <= group_ctr + STEP;
                end
        end

endmodule

`default_nettype wire

//--- logic/xoodoo_top.sv
`timescale 1ns/1ps
`default_nettype none

module xoodoo_top import xoodoo_pkg::*; #(
        parameter int ROUNDS_PER_CYCLE = 3
) (
        input  logic   eph1,
        input  logic   rst_n,

        // Input handshake
        input  logic   in_valid,
        output logic   in_ready,
        input  state_t in_state,

        // Output handshake
        output logic   out_valid,
        input  logic   out_ready,
        output state_t out_state
);

        // Strobes and round index from controller to datapath
        logic       load;
        logic       advance;
        round_idx_t round_base;

        // ------------------------------------------------------------------------
        // Elaboration checks
        // ------------------------------------------------------------------------

        // Groups must tile the 12 rounds exactly
        if (NUM_ROUNDS % ROUNDS_PER_CYCLE != 0) begin : g_bad_rpc
                $error("ROUNDS_PER_CYCLE must divide NUM_ROUNDS");
        end

        // ------------------------------------------------------------------------
        // Controller and datapath
        // ------------------------------------------------------------------------

        xoodoo_ctrl #(
                .ROUNDS_PER_CYCLE (ROUNDS_PER_CYCLE)
        ) xoodoo_ctrl_i (
                .eph1       (eph1),
                .rst_n      (rst_n),
                .in_valid   (in_valid),
                .out_ready  (out_ready),
                .in_ready   (in_ready),
                .out_valid  (out_valid),
                .load       (load),
                .advance    (advance),
                .round_base (round_base)
        );

        // Register output is the result once out_valid is up
        xoodoo_datapath #(
                .ROUNDS_PER_CYCLE (ROUNDS_PER_CYCLE)
        ) xoodoo_datapath_i (
                .eph1       (eph1),
                .rst_n      (rst_n),
                .load       (load),
                .advance    (advance),
                .in_state   (in_state),
                .round_base (round_base),
                .state_q    (out_state)
        );

endmodule

`default_nettype wire

//--- dv/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
        parameter int HALF_PERIOD  = 5,
        parameter int RESET_CYCLES = 8
) (
        output logic eph1,
        output logic rst_n
);

        // Free-running clock, 10 ns period with the default half period
        initial begin
                eph1 = 1'b0;
                forever begin
                        #(HALF_PERIOD) eph1 = ~eph1;
                end
        end

        // Reset low for RESET_CYCLES rising edges
        // Released on a falling edge, well clear of the flops
        initial begin
                rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge eph1);
                @(negedge eph1);
                rst_n = 1'b1;
        end

endmodule

`default_nettype wire

//--- dv/xoodoo_sva.sv
`timescale 1ns/1ps
`default_nettype none

module xoodoo_sva import xoodoo_pkg::*; #(
        parameter int LATENCY = 4
) (
        input logic   eph1,
        input logic   rst_n,
        input logic   in_valid,
        input logic   in_ready,
        input logic   out_valid,
        input logic   out_ready,
        input state_t out_state
);

        // Result shows up a fixed number of edges after the accept
        // Accept is sampled at edge k, out_valid is first sampled high at k+LATENCY+1
        a_latency: assert property (@(posedge eph1) disable iff (!rst_n)
                (in_valid && in_ready) |-> ##(LATENCY + 1) $rose(out_valid))
                else $error("out_valid did not rise %0d cycles after accept", LATENCY);

        // Back-pressure holds valid and data
        a_hold: assert property (@(posedge eph1) disable iff (!rst_n)
                (out_valid && !out_ready) |=> (out_valid && $stable(out_state)))
                else $error("out_valid or out_state changed while stalled");

        // Output transfer reopens the input on the same edge
        a_release: assert property (@(posedge eph1) disable iff (!rst_n)
                (out_valid && out_ready) |=> (in_ready && !out_valid))
                else $error("engine did not return to idle after output transfer");

endmodule

bind xoodoo_top xoodoo_sva xoodoo_sva_i (
        .eph1      (eph1),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_state (out_state)
);

`default_nettype wire

//--- dv/xoodoo_model.svh
`ifndef XOODOO_MODEL_SVH
`define XOODOO_MODEL_SVH

        // Galois taps, x^32 + x^22 + x^2 + x + 1 in right-shift form
        localparam logic [31:0] LFSR_TAPS = 32'h80200003;

        // One LFSR step, the bit taken is s[0] before the step
        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                if (s[0]) begin
                        return (s >> 1) ^ LFSR_TAPS;
                end
                return s >> 1;
        endfunction

        // Fill a whole state, one LFSR step per bit, bit 0 first
        task automatic lfsr_fill(inout logic [31:0] seed_q, output logic [STATE_W-1:0] v);
                for (int i = 0; i < STATE_W; i++) begin
                        v[i] = seed_q[0];
                        seed_q = lfsr_step(seed_q);
                end
        endtask

        // Cyclic shift toward higher z
        function automatic logic [31:0] rot_z(input logic [31:0] v, input int n);
                logic [63:0] d;
                d = {v, v} << n;
                return d[63:32];
        endfunction

        // ------------------------------------------------------------------------
        // Reference permutation, 12 rounds straight from the round definition
        // ------------------------------------------------------------------------

        function automatic state_t xoodoo_ref(input state_t s_in);
                logic [31:0] a [3][4];
                logic [31:0] b [3][4];
                logic [31:0] p [4];
                logic [31:0] e [4];
                state_t      s_out;
                for (int y = 0; y < 3; y++) begin
                        for (int x = 0; x < 4; x++) begin
                                a[y][x] = s_in[y][x];
                        end
                end
                for (int r = 0; r < NUM_ROUNDS; r++) begin
                        // Theta effect, parity of column x-1 at offsets 5 and 14
                        for (int x = 0; x < 4; x++) begin
                                p[x] = a[0][x] ^ a[1][x] ^ a[2][x];
                        end
                        for (int x = 0; x < 4; x++) begin
                                e[x] = rot_z(p[(x + 3) % 4], 5) ^ rot_z(p[(x + 3) % 4], 14);
                        end
                        // Theta folded into rho-west
                        for (int x = 0; x < 4; x++) begin
                                b[0][x] = a[0][x] ^ e[x];
                                b[1][x] = a[1][(x + 3) % 4] ^ e[(x + 3) % 4];
                                b[2][x] = rot_z(a[2][x] ^ e[x], 11);
                        end
                        // Iota
                        b[0][0] = b[0][0] ^ {20'h0, ROUND_CONST[r]};
                        // Chi
                        for (int y = 0; y < 3; y++) begin
                                for (int x = 0; x < 4; x++) begin
                                        a[y][x] = b[y][x] ^ (~b[(y + 1) % 3][x] & b[(y + 2) % 3][x]);
                                end
                        end
                        // Rho-east, plane 2 goes through b since lanes swap
                        for (int x = 0; x < 4; x++) begin
                                a[1][x] = rot_z(a[1][x], 1);
                                b[2][x] = rot_z(a[2][(x + 2) % 4], 8);
                        end
                        for (int x = 0; x < 4; x++) begin
                                a[2][x] = b[2][x];
                        end
                end
                for (int y = 0; y < 3; y++) begin
                        for (int x = 0; x < 4; x++) begin
                                s_out[y][x] = a[y][x];
                        end
                end
                return s_out;
        endfunction

`endif

//--- dv/xoodoo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module xoodoo_tb import xoodoo_pkg::*; ();

        `include "xoodoo_model.svh"

        localparam int          RPC        = 3;
        localparam int          LATENCY    = NUM_ROUNDS / RPC;
        localparam int          TIMEOUT    = 40;
        localparam logic [31:0] LFSR_SEED  = 32'h8611bee8;

        typedef logic [STATE_W-1:0] word_t;

        // ------------------------------------------------------------------------
        // Stimulus table, one transaction per row
        // ------------------------------------------------------------------------

        typedef enum logic [1:0] {
                K_ZERO,
                K_ONES,
                K_BIT,
                K_LFSR
        } stim_kind_e;

        // Kind, bit index for K_BIT, cycles of out_ready low
        typedef struct packed {
                stim_kind_e kind;
                int         bit_idx;
                int         hold;
        } stim_row_t;

        localparam int NUM_ROWS = 16;

        localparam stim_row_t STIM [NUM_ROWS] = '{
                '{K_ZERO, 0, 0},
                '{K_ONES, 0, 1},
                '{K_BIT, 0, 7},
                '{K_BIT, 31, 0},
                '{K_BIT, 128, 1},
                '{K_BIT, 383, 0},
                '{K_LFSR, 0, 0},
                '{K_LFSR, 0, 7},
                '{K_LFSR, 0, 1},
                '{K_LFSR, 0, 0},
                '{K_LFSR, 0, 0},
                '{K_LFSR, 0, 1},
                '{K_LFSR, 0, 7},
                '{K_LFSR, 0, 0},
                '{K_LFSR, 0, 1},
                '{K_LFSR, 0, 0}
        };

        logic   eph1;
        logic   rst_n;
        logic   in_valid;
        logic   in_ready;
        state_t in_state;
        logic   out_valid;
        logic   out_ready;
        state_t out_state;

        int          checks = 0;
        int          errors = 0;
        int unsigned cycle  = 0;
        logic [31:0] lfsr_q = LFSR_SEED;

        // Transfers seen on the DUT ports
        int          n_in   = 0;
        int          n_out  = 0;

        tb_clkgen #(
                .HALF_PERIOD  (5),
                .RESET_CYCLES (8)
        ) tb_clkgen_i (
                .eph1  (eph1),
                .rst_n (rst_n)
        );

        xoodoo_top #(
                .ROUNDS_PER_CYCLE (RPC)
        ) xoodoo_top_i (
                .eph1      (eph1),
                .rst_n     (rst_n),
                .in_valid  (in_valid),
                .in_ready  (in_ready),
                .in_state  (in_state),
                .out_valid (out_valid),
                .out_ready (out_ready),
                .out_state (out_state)
        );

        // Edge count, read 1 ns after each edge
        always @(posedge eph1) begin
                cycle <= cycle + 1;
        end

        // Input and output handshakes, counted on the transfer edge
        always @(posedge eph1) begin
                if (rst_n && in_valid && in_ready) begin
                        n_in <= n_in + 1;
                end
                if (rst_n && out_valid && out_ready) begin
                        n_out <= n_out + 1;
                end
        end

        task automatic check_value(input string name, input word_t got, input word_t exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("error: %s got 0x%h expected 0x%h", name, got, exp);
                end
        endtask

        // Poll in_ready or out_valid once per cycle, bounded
        task automatic wait_for(input bit on_output, output bit ok);
                int n;
                n = 0;
                while (!(on_output ? out_valid : in_ready) && n < TIMEOUT) begin
                        @(posedge eph1);
                        #1;
                        n++;
                end
                ok = on_output ? out_valid : in_ready;
                if (!ok) begin
                        errors++;
                        $display("timeout: %s stayed low for %0d cycles",
                                 on_output ? "out_valid" : "in_ready", TIMEOUT);
                end
        endtask

        task automatic build_input(input stim_row_t row, output state_t s);
                word_t flat;
                case (row.kind)
                        K_ZERO: begin
                                flat = '0;
                        end
                        K_ONES: begin
                                flat = '1;
                        end
                        K_BIT: begin
                                flat = word_t'(1) << row.bit_idx;
                        end
                        default: begin
                                lfsr_fill(lfsr_q, flat);
                        end
                endcase
                s = flat;
        endtask

        // ------------------------------------------------------------------------
        // Main sequence
        // ------------------------------------------------------------------------

        initial begin
                state_t      stim;
                state_t      expected;
                word_t       held;
                int unsigned accept_cycle;
                int          n;
                bit          ok;
                in_valid  = 1'b0;
                out_ready = 1'b0;
                in_state  = '0;
                n         = 0;
                // Bounded wait for reset release
                while (!rst_n && n < TIMEOUT) begin
                        @(posedge eph1);
                        #1;
                        n++;
                end
                if (!rst_n) begin
                        errors++;
                        $display("timeout: reset was never released");
                end
                // Idle state straight out of reset
                check_value("in_ready", word_t'(in_ready), word_t'(1));
                check_value("out_valid", word_t'(out_valid), word_t'(0));
                check_value("out_state", out_state, '0);

                // in_valid stays high across rows, so inputs queue back to back
                ok = rst_n;
                build_input(STIM[0], stim);
                in_state = stim;
                in_valid = 1'b1;
                for (int i = 0; i < NUM_ROWS && ok; i++) begin
                        expected = xoodoo_ref(in_state);
                        wait_for(1'b0, ok);
                        if (ok) begin
                                // Accept edge
                                @(posedge eph1);
                                #1;
                                accept_cycle = cycle;
                                check_value("in_ready", word_t'(in_ready), word_t'(0));
                                if (i + 1 < NUM_ROWS) begin
                                        build_input(STIM[i + 1], stim);
                                        in_state = stim;
                                end else begin
                                        in_valid = 1'b0;
                                end
                                wait_for(1'b1, ok);
                        end
                        if (ok) begin
                                check_value("latency", word_t'(cycle - accept_cycle),
                                            word_t'(LATENCY));
                                held = out_state;
                                check_value("out_state", held, expected);
                                // Back-pressure, everything frozen
                                for (int h = 0; h < STIM[i].hold; h++) begin
                                        @(posedge eph1);
                                        #1;
                                        check_value("out_valid", word_t'(out_valid), word_t'(1));
                                        check_value("in_ready", word_t'(in_ready), word_t'(0));
                                        check_value("out_state", out_state, held);
                                end
                                out_ready = 1'b1;
                                @(posedge eph1);
                                #1;
                                out_ready = 1'b0;
                                // Transfer edge drops out_valid and reopens input
                                check_value("out_valid", word_t'(out_valid), word_t'(0));
                                check_value("in_ready", word_t'(in_ready), word_t'(1));
                        end
                end
                in_valid = 1'b0;

                // Nothing extra afterwards
                for (int k = 0; k < 6; k++) begin
                        @(posedge eph1);
                        #1;
                        check_value("out_valid", word_t'(out_valid), word_t'(0));
                end

                // One accepted input per row and one output per input
                check_value("input count", word_t'(n_in), word_t'(NUM_ROWS));
                check_value("output count", word_t'(n_out), word_t'(NUM_ROWS));

                $display("checks %0d errors %0d", checks, errors);
                if (errors == 0) begin
                        $display("TEST RESULT: PASS");
                end else begin
                        $display("TEST RESULT: FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- src.f
+incdir+dv
logic/xoodoo_pkg.sv
logic/xoodoo_round.sv
logic/xoodoo_datapath.sv
logic/xoodoo_ctrl.sv
logic/xoodoo_top.sv
dv/tb_clkgen.sv
dv/xoodoo_sva.sv
dv/xoodoo_tb.sv

//--- run.sh
#!/bin/sh
# Build the Xoodoo testbench with Verilator, run it and look for the pass line

verilator --binary --timing --assert -j 0 --top-module xoodoo_tb -f src.f -o xoodoo_sim \
        && ./obj_dir/xoodoo_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
        && echo "run.sh: simulation passed" \
        || { echo "run.sh: build or simulation failed"; exit 1; }
